/* cl_scrub_pkg.sv */
//--------------------------------------------------------------------
// Scrubber glue shared types
// Channel numbering, control word layout, scrubber state and status
// used by the control, scrubber and identity readout blocks
//--------------------------------------------------------------------

package cl_scrub_pkg;

   //--------------------------------------------------------------------
   // Channel constants
   //--------------------------------------------------------------------

   // Number of DDR channels with a scrubber
   localparam int NUM_DDR = 4;

   // Bytes moved per data beat of a burst
   localparam int BYTES_PER_BEAT = 64;

   // Byte address into one DDR channel
   typedef logic [63:0] scrb_addr_t;

   // Channel order follows the enable bits of the control word,
   // so D sits below C here
   typedef enum logic [1:0] {
      DDR_A = 2'd0,
      DDR_B = 2'd1,
      DDR_D = 2'd2,
      DDR_C = 2'd3
   } ddr_ch_e;

   //--------------------------------------------------------------------
   // Control word
   //--------------------------------------------------------------------

   // Bit 31     debug enable for the ID words
   // Bits 30:28 debug channel select, values 4 to 7 fall back to DDR A
   // Bits 3:0   per-channel scrub enable, indexed by ddr_ch_e
   typedef struct packed {
      logic                dbg_en;
      logic [2:0]          dbg_sel;
      logic [23:0]         reserved;
      logic [NUM_DDR-1:0]  scrb_en;
   } ctl_word_t;

   //--------------------------------------------------------------------
   // Scrubber
   //--------------------------------------------------------------------

   // Walker states
   typedef enum logic [1:0] {
      SCRB_IDLE = 2'd0,
      SCRB_RUN  = 2'd1,
      SCRB_DONE = 2'd2
   } scrb_state_e;

   // Per-channel status seen by the readout and the done outputs
   typedef struct packed {
      logic       done;
      scrb_addr_t addr;
   } scrb_status_t;

endpackage

/* cl_scrub_ctl.sv */
//--------------------------------------------------------------------
// Scrubber control block
// Registers the control word for the datapath and answers function
// level reset requests with alternating done pulses
//--------------------------------------------------------------------

module cl_scrub_ctl
(
   input  logic                    clk,
   input  logic                    sync_rst_n,

   // Control word from the host side
   input  cl_scrub_pkg::ctl_word_t ctl0,

   // Function level reset request and response
   input  logic                    flr_assert,

   output cl_scrub_pkg::ctl_word_t ctl_q,
   output logic                    flr_done
);

   //--------------------------------------------------------------------
   // Control word register
   //--------------------------------------------------------------------

   // Enables and debug select are all taken from this copy
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         ctl_q <= '0;
      end
      else
      begin
         ctl_q <= ctl0;
      end
   end

   //--------------------------------------------------------------------
   // Reset request response
   //--------------------------------------------------------------------

   logic flr_assert_q;

   // Request is registered first, then answered
   // Done toggles against itself so a held request gives a pulse
   // on every second cycle
   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_assert_q <= 1'b0;
         flr_done     <= 1'b0;
      end
      else
      begin
         flr_assert_q <= flr_assert;
         flr_done     <= flr_assert_q && !flr_done;
      end
   end

   //--------------------------------------------------------------------
   // Checks
   //--------------------------------------------------------------------

   // Done is a single-cycle pulse, never two in a row
   flr_done_single_pulse: assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      flr_done |=> !flr_done
   );

endmodule

/* ddr_scrubber.sv */
//--------------------------------------------------------------------
// DDR scrubber address walker
// Steps through burst-aligned addresses of one channel from zero up
// to the last burst below the maximum address, then flags done
//--------------------------------------------------------------------

module ddr_scrubber
#(
   parameter cl_scrub_pkg::scrb_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                       SCRB_BURST_LEN_MINUS1 = 15
)
(
   input  logic                       clk,
   input  logic                       sync_rst_n,

   // Scrub enable level for this channel
   input  logic                       enable,

   output cl_scrub_pkg::scrb_status_t status
);

   // Bytes covered by one burst
   localparam cl_scrub_pkg::scrb_addr_t STEP =
      cl_scrub_pkg::scrb_addr_t'((SCRB_BURST_LEN_MINUS1 + 1) * cl_scrub_pkg::BYTES_PER_BEAT);

   // Start address of the final burst
   localparam cl_scrub_pkg::scrb_addr_t LAST_ADDR = SCRB_MAX_ADDR + 64'd1 - STEP;

   cl_scrub_pkg::scrb_state_e state_q;
   cl_scrub_pkg::scrb_state_e state_d;
   cl_scrub_pkg::scrb_addr_t  addr_q;
   cl_scrub_pkg::scrb_addr_t  addr_d;
   logic                      done_q;

   //--------------------------------------------------------------------
   // Next state
   //--------------------------------------------------------------------

   // No memory behind the walker, so one burst address per clock
   always_comb
   begin
      state_d = state_q;
      addr_d  = addr_q;
      if (!enable)
      begin
         state_d = cl_scrub_pkg::SCRB_IDLE;
         addr_d  = '0;
      end
      else
      begin
         case (state_q)
            cl_scrub_pkg::SCRB_IDLE:
            begin
               state_d = cl_scrub_pkg::SCRB_RUN;
               addr_d  = '0;
            end
            cl_scrub_pkg::SCRB_RUN:
            begin
               if (addr_q == LAST_ADDR)
                  state_d = cl_scrub_pkg::SCRB_DONE;
               else
                  addr_d = addr_q + STEP;
            end
            cl_scrub_pkg::SCRB_DONE:
            begin
               // Hold the last address until disabled
               state_d = cl_scrub_pkg::SCRB_DONE;
            end
            default:
            begin
               state_d = cl_scrub_pkg::SCRB_IDLE;
               addr_d  = '0;
            end
         endcase
      end
   end

   always_ff @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         state_q <= cl_scrub_pkg::SCRB_IDLE;
         addr_q  <= '0;
         done_q  <= 1'b0;
      end
      else
      begin
         state_q <= state_d;
         addr_q  <= addr_d;
         done_q  <= (state_d == cl_scrub_pkg::SCRB_DONE);
      end
   end

   assign status.done = done_q;
   assign status.addr = addr_q;

   // Walk stays inside the scrubbed region
   addr_in_range: assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      status.addr <= SCRB_MAX_ADDR
   );

   // Done flag tracks the state register
   done_matches_state: assert property (
      @(posedge clk) disable iff (!sync_rst_n)
      status.done == (state_q == cl_scrub_pkg::SCRB_DONE)
   );

endmodule

/* id_readout.sv */
//--------------------------------------------------------------------
// Identity readout
// Returns the two identity words, or with debug on the selected
// scrubber address split into low and high words
//--------------------------------------------------------------------

module id_readout
#(
   parameter logic [31:0] CL_ID0 = 32'hF001_1D0F,
   parameter logic [31:0] CL_ID1 = 32'h1D51_FEDC
)
(
   input  logic                       clk,

   input  cl_scrub_pkg::ctl_word_t    ctl_q,
   input  cl_scrub_pkg::scrb_status_t scrb_status [cl_scrub_pkg::NUM_DDR],

   output logic [31:0]                id0,
   output logic [31:0]                id1
);

   cl_scrub_pkg::ddr_ch_e    sel_ch;
   cl_scrub_pkg::scrb_addr_t sel_addr;

   // Selects above 3 fall back to DDR A
   always_comb
   begin
      if (ctl_q.dbg_sel[2])
         sel_ch = cl_scrub_pkg::DDR_A;
      else
         sel_ch = cl_scrub_pkg::ddr_ch_e'(ctl_q.dbg_sel[1:0]);
   end

   assign sel_addr = scrb_status[sel_ch].addr;

   // Debug on shows the selected address, otherwise the identity words
   always_ff @(posedge clk)
   begin
      if (ctl_q.dbg_en)
      begin
         id0 <= sel_addr[31:0];
         id1 <= sel_addr[63:32];
      end
      else
      begin
         id0 <= CL_ID0;
         id1 <= CL_ID1;
      end
   end

endmodule

/* cl_scrub_top.sv */
//--------------------------------------------------------------------
// Scrubber glue top level
// Control register, four DDR scrubbers and the identity readout
//--------------------------------------------------------------------

module cl_scrub_top
#(
   parameter cl_scrub_pkg::scrb_addr_t SCRB_MAX_ADDR         = 64'h1FFF,
   parameter int                       SCRB_BURST_LEN_MINUS1 = 15,
   parameter logic [31:0]              CL_ID0                = 32'hF001_1D0F,
   parameter logic [31:0]              CL_ID1                = 32'h1D51_FEDC
)
(
   input  logic                                clk,
   input  logic                                sync_rst_n,

   input  cl_scrub_pkg::ctl_word_t             ctl0,

   input  logic                                flr_assert,
   output logic                                flr_done,

   // One done bit per channel, in control word enable order
   output logic [cl_scrub_pkg::NUM_DDR-1:0]    scrb_done,

   output logic [31:0]                         id0,
   output logic [31:0]                         id1
);

   cl_scrub_pkg::ctl_word_t    ctl_q;
   cl_scrub_pkg::scrb_status_t scrb_status [cl_scrub_pkg::NUM_DDR];

   //--------------------------------------------------------------------
   // Control
   //--------------------------------------------------------------------

   cl_scrub_ctl ctl0_inst
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .flr_assert (flr_assert),
      .ctl_q      (ctl_q),
      .flr_done   (flr_done)
   );

   //--------------------------------------------------------------------
   // Scrubbers, one per channel
   //--------------------------------------------------------------------

   for (genvar i = 0; i < cl_scrub_pkg::NUM_DDR; i++)
   begin : g_scrb
      localparam cl_scrub_pkg::ddr_ch_e CH = cl_scrub_pkg::ddr_ch_e'(i);

      ddr_scrubber
      #(
         .SCRB_MAX_ADDR         (SCRB_MAX_ADDR),
         .SCRB_BURST_LEN_MINUS1 (SCRB_BURST_LEN_MINUS1)
      )
      scrb_inst
      (
         .clk        (clk),
         .sync_rst_n (sync_rst_n),
         .enable     (ctl_q.scrb_en[CH]),
         .status     (scrb_status[CH])
      );

      assign scrb_done[CH] = scrb_status[CH].done;
   end

   //--------------------------------------------------------------------
   // Identity readout
   //--------------------------------------------------------------------

   id_readout
   #(
      .CL_ID0 (CL_ID0),
      .CL_ID1 (CL_ID1)
   )
   id_inst
   (
      .clk         (clk),
      .ctl_q       (ctl_q),
      .scrb_status (scrb_status),
      .id0         (id0),
      .id1         (id1)
   );

endmodule

/* tb_clk_gen.sv */
//--------------------------------------------------------------------
// Testbench clock and reset generator
// Free-running clock and an active low reset held for a few cycles
//--------------------------------------------------------------------

module tb_clk_gen
#(
   parameter int PERIOD     = 40,
   parameter int RST_CYCLES = 3
)
(
   output logic clk,
   output logic sync_rst_n
);

   initial
   begin
      clk = 1'b0;
      forever #(PERIOD / 2) clk = ~clk;
   end

   // Reset drops on a falling edge, like every other input
   initial
   begin
      sync_rst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      sync_rst_n = 1'b1;
   end

endmodule

/* tb_cl_scrub.sv */
//--------------------------------------------------------------------
// Scrubber glue testbench
// Applies a table of control words, waits for the scrub done mask,
// checks the ID words and the reset request response
//--------------------------------------------------------------------

module tb_cl_scrub;

   localparam logic [31:0] CL_ID0      = 32'hF001_1D0F;
   localparam logic [31:0] CL_ID1      = 32'h1D51_FEDC;
   localparam logic [31:0] LAST_ADDR   = 32'h0000_1C00;
   localparam int          NUM_ENTRIES = 15;
   localparam int          WAIT_LIMIT  = 20;

   typedef struct packed {
      cl_scrub_pkg::ctl_word_t ctl;
      logic [3:0]              hold;
      logic [3:0]              mask;
      logic [31:0]             id0;
      logic [31:0]             id1;
   } entry_t;

   logic                             clk;
   logic                             sync_rst_n;
   cl_scrub_pkg::ctl_word_t          ctl0;
   logic                             flr_assert;
   logic                             flr_done;
   logic [cl_scrub_pkg::NUM_DDR-1:0] scrb_done;
   logic [31:0]                      id0;
   logic [31:0]                      id1;

   entry_t stim [NUM_ENTRIES];
   integer seed;

   // Reference model of the reset request response
   logic   flr_req_m;
   logic   flr_done_m;

   tb_clk_gen clk_gen0
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n)
   );

   cl_scrub_top dut0
   (
      .clk        (clk),
      .sync_rst_n (sync_rst_n),
      .ctl0       (ctl0),
      .flr_assert (flr_assert),
      .flr_done   (flr_done),
      .scrb_done  (scrb_done),
      .id0        (id0),
      .id1        (id1)
   );

   //--------------------------------------------------------------------
   // Failure reporting
   //--------------------------------------------------------------------

   task automatic stop_with_failure(input string why);
      $display("%s", why);
      $display("Finished with errors");
      $fatal(1, "Simulation stopped");
   endtask

   task automatic report_mismatch(input string name, input logic [63:0] got,
                                  input logic [63:0] exp);
      stop_with_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h",
                                  name, got, exp));
   endtask

   //--------------------------------------------------------------------
   // Stimulus table
   //--------------------------------------------------------------------

   function automatic entry_t make_entry(input logic [31:0] ctl, input logic [3:0] mask,
                                         input logic [31:0] exp_id0,
                                         input logic [31:0] exp_id1);
      entry_t e;
      e.ctl  = cl_scrub_pkg::ctl_word_t'(ctl);
      e.hold = 4'd1;
      e.mask = mask;
      e.id0  = exp_id0;
      e.id1  = exp_id1;
      return e;
   endfunction

   task automatic load_table();
      // Control word, done mask, expected id0, expected id1
      // Debug select 2 is DDR D on enable bit 2, select 3 is DDR C on bit 3
      stim[0]  = make_entry(32'h0000_0000, 4'h0, CL_ID0, CL_ID1);
      stim[1]  = make_entry(32'h0000_0001, 4'h1, CL_ID0, CL_ID1);
      stim[2]  = make_entry(32'h0000_0002, 4'h2, CL_ID0, CL_ID1);
      stim[3]  = make_entry(32'h0000_0004, 4'h4, CL_ID0, CL_ID1);
      stim[4]  = make_entry(32'h0000_0008, 4'h8, CL_ID0, CL_ID1);
      stim[5]  = make_entry(32'h0000_000F, 4'hF, CL_ID0, CL_ID1);
      stim[6]  = make_entry(32'h8000_000F, 4'hF, LAST_ADDR, 32'h0);
      stim[7]  = make_entry(32'h9000_0002, 4'h2, LAST_ADDR, 32'h0);
      stim[8]  = make_entry(32'hA000_0002, 4'h2, 32'h0, 32'h0);
      stim[9]  = make_entry(32'hB000_0008, 4'h8, LAST_ADDR, 32'h0);
      stim[10] = make_entry(32'hA000_0004, 4'h4, LAST_ADDR, 32'h0);
      // Select 5 falls back to DDR A
      stim[11] = make_entry(32'hD000_0001, 4'h1, LAST_ADDR, 32'h0);
      stim[12] = make_entry(32'hD000_0002, 4'h2, 32'h0, 32'h0);
      stim[13] = make_entry(32'h8000_0000, 4'h0, 32'h0, 32'h0);
      stim[14] = make_entry(32'h0000_0000, 4'h0, CL_ID0, CL_ID1);
      // Reset request hold of 1 to 8 cycles
      for (int i = 0; i < NUM_ENTRIES; i++)
      begin
         stim[i].hold = 4'(1 + ($unsigned($random(seed)) % 8));
      end
   endtask

   //--------------------------------------------------------------------
   // Reset request reference model and per-cycle check
   //--------------------------------------------------------------------

   // Done is high when the registered request was high and done was low
   always @(posedge clk or negedge sync_rst_n)
   begin
      if (!sync_rst_n)
      begin
         flr_req_m  <= 1'b0;
         flr_done_m <= 1'b0;
      end
      else
      begin
         flr_req_m  <= flr_assert;
         flr_done_m <= flr_req_m && !flr_done_m;
      end
   end

   always @(negedge clk)
   begin
      if (sync_rst_n)
      begin
         assert (flr_done === flr_done_m)
         else report_mismatch("flr_done", 64'(flr_done), 64'(flr_done_m));
      end
   end

   //--------------------------------------------------------------------
   // Sequence helpers
   //--------------------------------------------------------------------

   task automatic wait_for_mask(input logic [3:0] mask, input int idx);
      int cycles;
      cycles = 0;
      while (scrb_done !== mask)
      begin
         if (cycles >= WAIT_LIMIT)
            stop_with_failure($sformatf(
               "Entry %0d: scrb_done stayed at %h and never reached %h in %0d cycles",
               idx, scrb_done, mask, WAIT_LIMIT));
         else
         begin
            @(negedge clk);
            cycles++;
         end
      end
   endtask

   // A hold of h cycles gives (h + 1) / 2 done pulses
   task automatic run_reset_request(input int hold, input int idx);
      int pulses;
      int expected;
      pulses   = 0;
      expected = (hold + 1) / 2;
      for (int i = 0; i < hold + 4; i++)
      begin
         @(negedge clk);
         if (flr_done)
            pulses++;
         flr_assert = (i < hold);
      end
      assert (pulses == expected)
      else report_mismatch($sformatf("flr_done pulse count (entry %0d)", idx),
                           64'(pulses), 64'(expected));
   endtask

   //--------------------------------------------------------------------
   // Main sequence
   //--------------------------------------------------------------------

   initial
   begin
      ctl0         = '0;
      flr_assert   = 1'b0;
      seed         = 32'h3328a4e6;
      load_table();

      @(posedge sync_rst_n);
      @(negedge clk);
      assert (flr_done === 1'b0)
      else report_mismatch("flr_done after reset", 64'(flr_done), 64'h0);
      assert (scrb_done === 4'h0)
      else report_mismatch("scrb_done after reset", 64'(scrb_done), 64'h0);
      assert (id0 === CL_ID0)
      else report_mismatch("id0 after reset", 64'(id0), 64'(CL_ID0));
      assert (id1 === CL_ID1)
      else report_mismatch("id1 after reset", 64'(id1), 64'(CL_ID1));

      for (int n = 0; n < NUM_ENTRIES; n++)
      begin
         @(negedge clk);
         ctl0 = stim[n].ctl;
         @(negedge clk);
         wait_for_mask(stim[n].mask, n);
         // Let the ID words catch up with the control word and status
         repeat (2) @(negedge clk);
         assert (scrb_done === stim[n].mask)
         else report_mismatch($sformatf("scrb_done (entry %0d)", n),
                              64'(scrb_done), 64'(stim[n].mask));
         assert (id0 === stim[n].id0)
         else report_mismatch($sformatf("id0 (entry %0d)", n), 64'(id0), 64'(stim[n].id0));
         assert (id1 === stim[n].id1)
         else report_mismatch($sformatf("id1 (entry %0d)", n), 64'(id1), 64'(stim[n].id1));
         run_reset_request(int'(stim[n].hold), n);
      end

      $display("Finished with no errors");
      $finish;
   end

   // Watchdog sized from the table length
   initial
   begin
      repeat (NUM_ENTRIES * 30 + 20) @(posedge clk);
      stop_with_failure("Watchdog expired before the test sequence finished");
   end

endmodule

/* src.f */
cl_scrub_pkg.sv
cl_scrub_ctl.sv
ddr_scrubber.sv
id_readout.sv
cl_scrub_top.sv
tb_clk_gen.sv
tb_cl_scrub.sv

/* Makefile */
# Verilator build and run for the scrubber glue testbench

VERILATOR  ?= verilator
SIM_FLAGS  ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
TOP        ?= tb_cl_scrub
RTL_TOP    ?= cl_scrub_top
FILELIST   ?= src.f
OBJ_DIR    ?= obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Exit status of the simulation is the pass or fail result
run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
